/* verilog.f */
rtl/mem_pkg.sv
rtl/core_pkg.sv
rtl/mem_bus_if.sv
rtl/alu.sv
rtl/ifu.sv
rtl/idu.sv
rtl/exu.sv
rtl/mem_arbiter.sv
rtl/core_top.sv
testbench/tb_core.sv

/* Bender.yml */
package:
  name: rv32i_core

sources:
  - files:
      - rtl/mem_pkg.sv
      - rtl/core_pkg.sv
      - rtl/mem_bus_if.sv
      - rtl/alu.sv
      - rtl/ifu.sv
      - rtl/idu.sv
      - rtl/exu.sv
      - rtl/mem_arbiter.sv
      - rtl/core_top.sv
  - target: test
    files:
      - testbench/tb_core.sv

/* testbench/tb_core.sv */
// core testbench: directed rv32i programs run against a word-array sram model
`timescale 1ns/1ps

module tb_core;

	localparam int addr_width = 16;
	localparam logic [31:0] reset_pc = 32'h0;
	localparam int mem_words = 1 << (addr_width - 2);
	localparam int n_tests = 6;
	// tests x 64 instructions x 4 cycles x 8 ns, plus reset and halt cycles
	localparam int limit_ns = n_tests * 64 * 4 * 8 + 4000;
	localparam logic [31:0] res_base = 32'h400;
	localparam logic [31:0] data_base = 32'h300;
	localparam logic [31:0] ebreak = 32'h0010_0073;

	logic                  clk = 1'b0;
	logic                  rst_n;
	logic                  mem_req;
	logic                  mem_we;
	logic [addr_width-1:0] mem_addr;
	logic [31:0]           mem_wdata;
	logic [3:0]            mem_wstrb;
	logic [31:0]           mem_rdata;
	logic                  halt;

	logic [31:0] mem [0:mem_words-1];
	logic [31:0] prog [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_val [$];
	logic [3:0]  exp_strb [$];
	logic        rd_pend;
	logic [13:0] rd_idx;
	int          seed = 32'hd2ac87bf;
	int          errors = 0;
	int          checks = 0;
	int          test_errors;
	int          test_checks;
	int          slot;
	string       cur_test;

	always #4 clk = ~clk;

	core_top #(.addr_width(addr_width), .reset_pc(reset_pc)) dut0 (
		.clk, .rst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wstrb,
		.mem_rdata, .halt
	);

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		test_checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp);
		end
	endtask

	// sram model, sampled mid-cycle; read data shows up one cycle after the request
	always @(negedge clk) begin
		if (!rst_n) begin
			rd_pend = 1'b0;
		end else begin
			if (rd_pend)
				mem_rdata = mem[rd_idx];
			rd_pend = mem_req && !mem_we;
			rd_idx  = mem_addr[15:2];
			if (mem_req && mem_we) begin
				if (exp_strb.size() == 0) begin
					errors++;
					test_errors++;
					$display("unexpected memory write at %0t ns to address %h", $time, mem_addr);
				end else begin
					check("mem_wstrb", mem_wstrb, exp_strb.pop_front());
				end
				for (int b = 0; b < 4; b++)
					if (mem_wstrb[b])
						mem[mem_addr[15:2]][8*b +: 8] = mem_wdata[8*b +: 8];
			end
		end
	end

	// unwritten memory, unique per word
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {2'b10, addr[15:2] ^ 14'h2b5d, 2'b01, ~addr[15:2]};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	// byte lanes a store of this size touches at this offset
	function automatic logic [3:0] strobe_for(input logic [1:0] size, input logic [1:0] off);
		case (size)
			2'b00:   return 4'b0001 << off;
			2'b01:   return 4'b0011 << off;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic branch_rule(input logic [2:0] f3, input logic [31:0] x,
			input logic [31:0] y);
		case (f3)
			3'b000:  return x == y;
			3'b001:  return x != y;
			3'b100:  return $signed(x) < $signed(y);
			3'b101:  return $signed(x) >= $signed(y);
			3'b110:  return x < y;
			default: return x >= y;
		endcase
	endfunction

	function automatic logic [31:0] next_pc();
		return reset_pc + 32'(4 * prog.size());
	endfunction

	task automatic emit(input logic [31:0] word);
		prog.push_back(word);
	endtask

	task automatic expect_word(input logic [31:0] addr, input logic [31:0] val);
		exp_addr.push_back(addr);
		exp_val.push_back(val);
	endtask

	// lui + addi, always two instructions
	task automatic load_imm(input logic [4:0] rd, input logic [31:0] val);
		logic [31:0] upper;
		upper = val + 32'h800;
		emit({upper[31:12], rd, 7'b0110111});
		emit(enc_i(val[11:0], rd, 3'b000, rd, 7'b0010011));
	endtask

	task automatic emit_store(input logic [2:0] f3, input logic [4:0] rs2,
			input logic [11:0] addr);
		emit(enc_s(addr, rs2, 5'd0, f3));
		exp_strb.push_back(strobe_for(f3[1:0], addr[1:0]));
	endtask

	task automatic save_result(input logic [4:0] rs2, input logic [31:0] val);
		logic [31:0] addr;
		addr = res_base + 4 * slot;
		slot++;
		emit_store(3'b010, rs2, addr[11:0]);
		expect_word(addr, val);
	endtask

	// store on a path that must be skipped
	task automatic emit_marker(input logic [31:0] addr);
		emit(enc_s(addr[11:0], 5'd1, 5'd0, 3'b010));
		expect_word(addr, fill_word(addr));
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errors = 0;
		test_checks = 0;
		slot = 0;
		prog.delete();
		exp_addr.delete();
		exp_val.delete();
		exp_strb.delete();
		for (int i = 0; i < mem_words; i++)
			mem[i] = fill_word(32'(i) << 2);
	endtask

	task automatic run_program(input int post_cycles);
		logic [31:0] a;
		foreach (prog[i])
			mem[reset_pc[15:2] + i] = prog[i];
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) begin
			@(negedge clk);
			check("mem_req in reset", mem_req, 1'b0);
			check("halt in reset", halt, 1'b0);
		end
		rst_n = 1'b1;
		@(negedge clk);
		check("first fetch request", mem_req, 1'b1);
		check("first fetch address", mem_addr, reset_pc[addr_width-1:0]);
		// the watchdog bounds this wait
		while (!halt)
			@(negedge clk);
		repeat (post_cycles) begin
			@(negedge clk);
			check("halt level", halt, 1'b1);
			check("mem_req after halt", mem_req, 1'b0);
		end
		foreach (exp_addr[i]) begin
			a = exp_addr[i];
			check($sformatf("word at %h", a), mem[a[15:2]], exp_val[i]);
		end
		check("stores not issued", exp_strb.size(), 0);
		$display("test %-12s %0d checks, %0d errors", cur_test, test_checks, test_errors);
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [31:0] simm;
		begin_test("alu");
		a = $random(seed);
		b = $random(seed);
		imm = $random(seed);
		simm = {{20{imm[11]}}, imm};
		load_imm(5'd1, a);
		load_imm(5'd2, b);
		// register forms, x3 = x1 op x2
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		save_result(5'd3, a + b);
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));
		save_result(5'd3, a - b);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3));
		save_result(5'd3, a & b);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3));
		save_result(5'd3, a | b);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3));
		save_result(5'd3, a ^ b);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
		save_result(5'd3, a << b[4:0]);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3));
		save_result(5'd3, a >> b[4:0]);
		emit(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));
		save_result(5'd3, $signed(a) >>> b[4:0]);
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3));
		save_result(5'd3, {31'b0, $signed(a) < $signed(b)});
		emit(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3));
		save_result(5'd3, {31'b0, a < b});
		// immediate forms
		emit(enc_i(imm, 5'd1, 3'b000, 5'd3, 7'b0010011));
		save_result(5'd3, a + simm);
		emit(enc_i(imm, 5'd1, 3'b010, 5'd3, 7'b0010011));
		save_result(5'd3, {31'b0, $signed(a) < $signed(simm)});
		emit(enc_i(imm, 5'd1, 3'b011, 5'd3, 7'b0010011));
		save_result(5'd3, {31'b0, a < simm});
		emit(enc_i(imm, 5'd1, 3'b100, 5'd3, 7'b0010011));
		save_result(5'd3, a ^ simm);
		emit(enc_i(imm, 5'd1, 3'b110, 5'd3, 7'b0010011));
		save_result(5'd3, a | simm);
		emit(enc_i(imm, 5'd1, 3'b111, 5'd3, 7'b0010011));
		save_result(5'd3, a & simm);
		emit(enc_i({7'h00, imm[4:0]}, 5'd1, 3'b001, 5'd3, 7'b0010011));
		save_result(5'd3, a << imm[4:0]);
		emit(enc_i({7'h00, imm[4:0]}, 5'd1, 3'b101, 5'd3, 7'b0010011));
		save_result(5'd3, a >> imm[4:0]);
		emit(enc_i({7'h20, imm[4:0]}, 5'd1, 3'b101, 5'd3, 7'b0010011));
		save_result(5'd3, $signed(a) >>> imm[4:0]);
		emit(ebreak);
		run_program(4);
	endtask

	task automatic test_loads();
		logic [31:0] w;
		logic [7:0]  lane8;
		logic [15:0] lane16;
		begin_test("loads");
		w = $random(seed);
		mem[data_base[15:2]] = w;
		for (int off = 0; off < 4; off++) begin
			lane8 = w[8*off +: 8];
			emit(enc_i(data_base[11:0] + off, 5'd0, 3'b000, 5'd3, 7'b0000011));
			save_result(5'd3, {{24{lane8[7]}}, lane8});
			emit(enc_i(data_base[11:0] + off, 5'd0, 3'b100, 5'd3, 7'b0000011));
			save_result(5'd3, {24'b0, lane8});
		end
		for (int h = 0; h < 2; h++) begin
			lane16 = w[16*h +: 16];
			emit(enc_i(data_base[11:0] + 2*h, 5'd0, 3'b001, 5'd3, 7'b0000011));
			save_result(5'd3, {{16{lane16[15]}}, lane16});
			emit(enc_i(data_base[11:0] + 2*h, 5'd0, 3'b101, 5'd3, 7'b0000011));
			save_result(5'd3, {16'b0, lane16});
		end
		emit(enc_i(data_base[11:0], 5'd0, 3'b010, 5'd3, 7'b0000011));
		save_result(5'd3, w);
		emit(ebreak);
		run_program(4);
	endtask

	task automatic test_stores();
		logic [31:0] d;
		logic [31:0] addr;
		logic [31:0] word;
		begin_test("stores");
		d = $random(seed);
		load_imm(5'd1, d);
		// one sb per word, each at a different lane
		for (int off = 0; off < 4; off++) begin
			addr = data_base + 4*off + off;
			word = fill_word(addr);
			word[8*off +: 8] = d[7:0];
			emit_store(3'b000, 5'd1, addr[11:0]);
			expect_word(addr & ~32'h3, word);
		end
		for (int h = 0; h < 2; h++) begin
			addr = data_base + 16 + 4*h + 2*h;
			word = fill_word(addr);
			word[16*h +: 16] = d[15:0];
			emit_store(3'b001, 5'd1, addr[11:0]);
			expect_word(addr & ~32'h3, word);
		end
		addr = data_base + 24;
		emit_store(3'b010, 5'd1, addr[11:0]);
		expect_word(addr, d);
		emit(ebreak);
		run_program(4);
	endtask

	task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [31:0] x, input logic [31:0] y,
			input logic [31:0] v);
		logic [31:0] nt_addr;
		logic [31:0] t_addr;
		logic        taken;
		nt_addr = res_base + 4 * slot;
		t_addr = nt_addr + 4;
		slot += 2;
		taken = branch_rule(f3, x, y);
		emit(enc_b(13'd12, rs2, rs1, f3));
		emit(enc_s(nt_addr[11:0], 5'd7, 5'd0, 3'b010));
		emit(enc_j(21'd8, 5'd0));
		emit(enc_s(t_addr[11:0], 5'd7, 5'd0, 3'b010));
		exp_strb.push_back(4'b1111);
		expect_word(taken ? t_addr : nt_addr, v);
		expect_word(taken ? nt_addr : t_addr, fill_word(taken ? nt_addr : t_addr));
	endtask

	task automatic test_branches();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		begin_test("branches");
		// a negative, b positive: signed and unsigned orders disagree
		a = $random(seed) | 32'h8000_0000;
		b = $random(seed) & 32'h7fff_ffff;
		v = $random(seed);
		load_imm(5'd1, a);
		load_imm(5'd2, b);
		load_imm(5'd7, v);
		branch_case(3'b000, 5'd1, 5'd1, a, a, v);
		branch_case(3'b000, 5'd1, 5'd2, a, b, v);
		branch_case(3'b001, 5'd1, 5'd1, a, a, v);
		branch_case(3'b001, 5'd1, 5'd2, a, b, v);
		for (int f = 4; f < 8; f++) begin
			branch_case(3'(f), 5'd1, 5'd2, a, b, v);
			branch_case(3'(f), 5'd2, 5'd1, b, a, v);
		end
		emit(ebreak);
		run_program(4);
	endtask

	task automatic test_jumps();
		logic [31:0] land;
		logic [31:0] jal_pc;
		logic [31:0] jalr_pc;
		begin_test("jumps");
		// li, jal, 2 markers, sw, jalr, 2 markers, then the landing site
		land = reset_pc + 36;
		load_imm(5'd1, land | 32'h1);
		jal_pc = next_pc();
		emit(enc_j(21'd12, 5'd5));
		emit_marker(32'h600);
		emit_marker(32'h604);
		save_result(5'd5, jal_pc + 4);
		jalr_pc = next_pc();
		emit(enc_i(12'd0, 5'd1, 3'b000, 5'd6, 7'b1100111));
		emit_marker(32'h608);
		emit_marker(32'h60c);
		save_result(5'd6, jalr_pc + 4);
		emit(ebreak);
		run_program(4);
	endtask

	task automatic test_reset_halt();
		logic [31:0] v;
		begin_test("reset_halt");
		v = $random(seed);
		load_imm(5'd1, v);
		save_result(5'd1, v);
		emit(ebreak);
		// never fetched once halted
		emit_marker(32'h610);
		emit_marker(32'h614);
		run_program(32);
	endtask

	initial begin
		rst_n = 1'b0;
		mem_rdata = '0;
		rd_pend = 1'b0;
		rd_idx = '0;
		test_alu();
		test_loads();
		test_stores();
		test_branches();
		test_jumps();
		test_reset_halt();
		$display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		#(limit_ns);
		$display("watchdog: run did not finish within %0d ns, core likely hung", limit_ns);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* rtl/core_top.sv */
// core top: multicycle rv32i core with one synchronous sram port
`timescale 1ns/1ps

module core_top #(
	parameter int addr_width = 16,
	parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                  clk,
	input  logic                  rst_n,
	output logic                  mem_req,
	output logic                  mem_we,
	output logic [addr_width-1:0] mem_addr,
	output logic [31:0]           mem_wdata,
	output logic [3:0]            mem_wstrb,
	input  logic [31:0]           mem_rdata,
	output logic                  halt
);

	logic [31:0]                     inst;
	logic [core_pkg::xlen-1:0]       pc;
	logic                            inst_valid;
	logic [core_pkg::xlen-1:0]       src1;
	logic [core_pkg::xlen-1:0]       src2;
	logic [core_pkg::xlen-1:0]       imm;
	logic [core_pkg::reg_addr_w-1:0] rd;
	core_pkg::ctrl_t                 ctrl;
	logic                            commit;
	logic                            branch_taken;
	logic [core_pkg::xlen-1:0]       branch_target;
	logic                            wb_en;
	logic [core_pkg::reg_addr_w-1:0] wb_addr;
	logic [core_pkg::xlen-1:0]       wb_data;

	mem_bus_if #(.addr_width(addr_width)) fetch_bus ();
	mem_bus_if #(.addr_width(addr_width)) data_bus ();

	ifu #(.addr_width(addr_width), .reset_pc(reset_pc)) ifu0 (
		.clk, .rst_n, .bus(fetch_bus), .commit, .branch_taken, .branch_target,
		.halt, .inst, .pc, .inst_valid
	);

	idu idu0 (
		.clk, .rst_n, .inst, .wb_en, .wb_addr, .wb_data,
		.src1, .src2, .imm, .rd, .ctrl
	);

	exu #(.addr_width(addr_width)) exu0 (
		.clk, .rst_n, .inst_valid, .pc, .src1, .src2, .imm, .rd, .ctrl,
		.bus(data_bus), .commit, .branch_taken, .branch_target,
		.wb_en, .wb_addr, .wb_data, .halt
	);

	mem_arbiter #(.addr_width(addr_width)) arb0 (
		.clk, .rst_n, .fetch(fetch_bus), .data(data_bus),
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_wstrb, .mem_rdata
	);

endmodule

/* rtl/mem_arbiter.sv */
// memory arbiter: data over fetch onto one sram port, read data back to its owner
`timescale 1ns/1ps

module mem_arbiter #(
	parameter int addr_width = 16
) (
	input  logic                  clk,
	input  logic                  rst_n,
	mem_bus_if.arbiter            fetch,
	mem_bus_if.arbiter            data,
	output logic                  mem_req,
	output logic                  mem_we,
	output logic [addr_width-1:0] mem_addr,
	output logic [31:0]           mem_wdata,
	output logic [3:0]            mem_wstrb,
	input  logic [31:0]           mem_rdata
);

	logic data_sel;
	logic rd_pend;
	// owner of the read in flight
	logic rd_data;

	assign data_sel   = data.req;
	assign data.gnt   = data.req;
	assign fetch.gnt  = fetch.req && !data.req;

	assign mem_req   = data.req || fetch.req;
	assign mem_we    = data_sel ? data.we    : fetch.we;
	assign mem_addr  = data_sel ? data.addr  : fetch.addr;
	assign mem_wdata = data_sel ? data.wdata : fetch.wdata;
	assign mem_wstrb = data_sel ? data.wstrb : fetch.wstrb;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_pend <= 1'b0;
			rd_data <= 1'b0;
		end else begin
			rd_pend <= mem_req && !mem_we;
			if (mem_req)
				rd_data <= data_sel;
		end
	end

	assign fetch.rvalid = rd_pend && !rd_data;
	assign data.rvalid  = rd_pend && rd_data;
	assign fetch.rdata  = mem_rdata;
	assign data.rdata   = mem_rdata;

endmodule

/* rtl/exu.sv */
// execute unit: alu, branch resolution, load/store data path and write-back
`timescale 1ns/1ps

module exu #(
	parameter int addr_width = 16
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            inst_valid,
	input  logic [core_pkg::xlen-1:0]       pc,
	input  logic [core_pkg::xlen-1:0]       src1,
	input  logic [core_pkg::xlen-1:0]       src2,
	input  logic [core_pkg::xlen-1:0]       imm,
	input  logic [core_pkg::reg_addr_w-1:0] rd,
	input  core_pkg::ctrl_t                 ctrl,
	mem_bus_if.requester                    bus,
	output logic                            commit,
	output logic                            branch_taken,
	output logic [core_pkg::xlen-1:0]       branch_target,
	output logic                            wb_en,
	output logic [core_pkg::reg_addr_w-1:0] wb_addr,
	output logic [core_pkg::xlen-1:0]       wb_data,
	output logic                            halt
);

	logic [core_pkg::xlen-1:0] alu_a;
	logic [core_pkg::xlen-1:0] alu_b;
	logic [core_pkg::xlen-1:0] alu_result;
	logic [core_pkg::xlen-1:0] load_data;
	logic [1:0]                byte_off;
	logic [7:0]                lane_b;
	logic [15:0]               lane_h;
	logic                      sext;
	logic [3:0]                strb;
	logic                      ld_wait;
	mem_pkg::mem_word_u        st_word;
	mem_pkg::mem_word_u        ld_word;

	assign alu_a = ctrl.use_pc ? pc : src1;
	assign alu_b = ctrl.use_imm ? imm : src2;

	alu alu0 (
		.op     (ctrl.alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result)
	);

	// alu compares for branches, adds for jumps and addresses
	assign branch_taken  = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && alu_result[0]);
	assign branch_target = ctrl.is_branch ? pc + imm : {alu_result[core_pkg::xlen-1:1], 1'b0};

	assign byte_off = alu_result[1:0];

	// store lanes replicated, strobes pick the addressed ones
	always_comb begin
		case (ctrl.mem_size)
			mem_pkg::size_byte: begin
				st_word.bytes = {4{src2[7:0]}};
				strb          = 4'b0001 << byte_off;
			end
			mem_pkg::size_half: begin
				st_word.halves = {2{src2[15:0]}};
				strb           = 4'b0011 << {byte_off[1], 1'b0};
			end
			default: begin
				st_word.word = src2;
				strb         = 4'b1111;
			end
		endcase
	end

	assign ld_word.word = bus.rdata;
	assign lane_b       = ld_word.bytes[byte_off];
	assign lane_h       = ld_word.halves[byte_off[1]];
	assign sext         = (ctrl.load_kind == mem_pkg::ext_signed);

	always_comb begin
		case (ctrl.mem_size)
			mem_pkg::size_byte: load_data = {{24{sext & lane_b[7]}}, lane_b};
			mem_pkg::size_half: load_data = {{16{sext & lane_h[15]}}, lane_h};
			default:            load_data = ld_word.word;
		endcase
	end

	// one access per instruction, load request drops once issued
	assign bus.req   = inst_valid && (ctrl.is_store || (ctrl.is_load && !ld_wait));
	assign bus.we    = ctrl.is_store;
	assign bus.addr  = alu_result[addr_width-1:0];
	assign bus.wdata = st_word.word;
	assign bus.wstrb = ctrl.is_store ? strb : 4'b0000;

	always_comb begin
		if (!inst_valid)
			commit = 1'b0;
		else if (ctrl.is_store)
			commit = bus.gnt;
		else if (ctrl.is_load)
			commit = ld_wait && bus.rvalid;
		else
			commit = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ld_wait <= 1'b0;
			halt    <= 1'b0;
		end else begin
			if (ld_wait && bus.rvalid)
				ld_wait <= 1'b0;
			else if (inst_valid && ctrl.is_load && bus.gnt)
				ld_wait <= 1'b1;
			if (commit && ctrl.halt)
				halt <= 1'b1;
		end
	end

	assign wb_en   = commit && ctrl.reg_wen;
	assign wb_addr = rd;
	assign wb_data = (ctrl.is_jal || ctrl.is_jalr) ? pc + 32'd4 :
	                 ctrl.is_load                  ? load_data  :
	                                                 alu_result;

endmodule

/* rtl/idu.sv */
// decode unit: rv32i decoder, immediate generation and register file
`timescale 1ns/1ps

module idu (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [31:0]                     inst,
	input  logic                            wb_en,
	input  logic [core_pkg::reg_addr_w-1:0] wb_addr,
	input  logic [core_pkg::xlen-1:0]       wb_data,
	output logic [core_pkg::xlen-1:0]       src1,
	output logic [core_pkg::xlen-1:0]       src2,
	output logic [core_pkg::xlen-1:0]       imm,
	output logic [core_pkg::reg_addr_w-1:0] rd,
	output core_pkg::ctrl_t                 ctrl
);

	logic [core_pkg::xlen-1:0]       regs [1:31];
	logic [core_pkg::reg_addr_w-1:0] rs1_addr;
	logic [core_pkg::reg_addr_w-1:0] rs2_addr;
	logic [6:0]                      opcode;
	logic [2:0]                      funct3;
	logic                            alt;

	assign opcode   = inst[6:0];
	assign funct3   = inst[14:12];
	assign rd       = inst[11:7];
	assign rs2_addr = inst[24:20];
	// inst[30] selects sub/sra, but only sra for immediates
	assign alt      = inst[30] && (opcode == core_pkg::op_reg || funct3 == 3'b101);

	function automatic core_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic sel);
		case (f3)
			3'b000:  return sel ? core_pkg::alu_sub : core_pkg::alu_add;
			3'b001:  return core_pkg::alu_sll;
			3'b010:  return core_pkg::alu_slt;
			3'b011:  return core_pkg::alu_sltu;
			3'b100:  return core_pkg::alu_xor;
			3'b101:  return sel ? core_pkg::alu_sra : core_pkg::alu_srl;
			3'b110:  return core_pkg::alu_or;
			default: return core_pkg::alu_and;
		endcase
	endfunction

	function automatic core_pkg::alu_op_e branch_op(input logic [2:0] f3);
		case (f3)
			3'b000:  return core_pkg::alu_eq;
			3'b001:  return core_pkg::alu_ne;
			3'b100:  return core_pkg::alu_lt;
			3'b101:  return core_pkg::alu_ge;
			3'b110:  return core_pkg::alu_ltu;
			default: return core_pkg::alu_geu;
		endcase
	endfunction

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = core_pkg::alu_add;
		imm         = {{20{inst[31]}}, inst[31:20]};
		rs1_addr    = inst[19:15];
		case (opcode)
			core_pkg::op_lui: begin
				// x0 + imm
				rs1_addr     = '0;
				imm          = {inst[31:12], 12'b0};
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			core_pkg::op_auipc: begin
				imm          = {inst[31:12], 12'b0};
				ctrl.use_pc  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			core_pkg::op_jal: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
				ctrl.is_jal  = 1'b1;
				ctrl.use_pc  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			core_pkg::op_jalr: begin
				ctrl.is_jalr = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
			end
			core_pkg::op_branch: begin
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
				ctrl.is_branch = 1'b1;
				ctrl.alu_op    = branch_op(funct3);
			end
			core_pkg::op_load: begin
				ctrl.is_load   = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_wen   = 1'b1;
				ctrl.mem_size  = mem_pkg::mem_size_e'(funct3[1:0]);
				ctrl.load_kind = mem_pkg::load_kind_e'(funct3[2]);
			end
			core_pkg::op_store: begin
				imm           = {{20{inst[31]}}, inst[31:25], inst[11:7]};
				ctrl.is_store = 1'b1;
				ctrl.use_imm  = 1'b1;
				ctrl.mem_size = mem_pkg::mem_size_e'(funct3[1:0]);
			end
			core_pkg::op_imm: begin
				ctrl.use_imm = 1'b1;
				ctrl.reg_wen = 1'b1;
				ctrl.alu_op  = arith_op(funct3, alt);
			end
			core_pkg::op_reg: begin
				ctrl.reg_wen = 1'b1;
				ctrl.alu_op  = arith_op(funct3, alt);
			end
			core_pkg::op_system: ctrl.halt = (inst == 32'h0010_0073);
			default: ;
		endcase
	end

	// x0 is not stored
	assign src1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign src2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

endmodule

/* rtl/ifu.sv */
// fetch unit: program counter, fetch sequencing and instruction register
`timescale 1ns/1ps

module ifu #(
	parameter int addr_width = 16,
	parameter logic [core_pkg::xlen-1:0] reset_pc = '0
) (
	input  logic                      clk,
	input  logic                      rst_n,
	mem_bus_if.requester              bus,
	input  logic                      commit,
	input  logic                      branch_taken,
	input  logic [core_pkg::xlen-1:0] branch_target,
	input  logic                      halt,
	output logic [31:0]               inst,
	output logic [core_pkg::xlen-1:0] pc,
	output logic                      inst_valid
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_req  = 2'd1;
	localparam logic [1:0] st_wait = 2'd2;
	localparam logic [1:0] st_hold = 2'd3;

	logic [1:0] state;

	// read-only requester
	assign bus.req    = (state == st_req) && !halt;
	assign bus.we     = 1'b0;
	assign bus.addr   = pc[addr_width-1:0];
	assign bus.wdata  = '0;
	assign bus.wstrb  = '0;
	assign inst_valid = (state == st_hold);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			pc    <= reset_pc;
		end else begin
			case (state)
				st_idle: if (!halt) state <= st_req;
				st_req: begin
					if (halt)
						state <= st_idle;
					else if (bus.gnt)
						state <= st_wait;
				end
				st_wait: if (bus.rvalid) state <= st_hold;
				default: begin
					// next fetch starts the cycle after commit
					if (commit) begin
						state <= st_req;
						pc    <= branch_taken ? branch_target : pc + 32'd4;
					end
				end
			endcase
		end
	end

	// instruction register, payload only
	always_ff @(posedge clk) begin
		if (state == st_wait && bus.rvalid)
			inst <= bus.rdata;
	end

endmodule

/* rtl/alu.sv */
// alu: arithmetic, logic, shift and compare operations
`timescale 1ns/1ps

module alu (
	input  core_pkg::alu_op_e         op,
	input  logic [core_pkg::xlen-1:0] a,
	input  logic [core_pkg::xlen-1:0] b,
	output logic [core_pkg::xlen-1:0] result
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;

	assign shamt = b[4:0];
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			core_pkg::alu_add:  result = a + b;
			core_pkg::alu_sub:  result = a - b;
			core_pkg::alu_and:  result = a & b;
			core_pkg::alu_or:   result = a | b;
			core_pkg::alu_xor:  result = a ^ b;
			core_pkg::alu_sll:  result = a << shamt;
			core_pkg::alu_srl:  result = a >> shamt;
			core_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
			// compares, 0 or 1
			core_pkg::alu_slt,
			core_pkg::alu_lt:   result = {31'b0, lt_s};
			core_pkg::alu_sltu,
			core_pkg::alu_ltu:  result = {31'b0, lt_u};
			core_pkg::alu_eq:   result = {31'b0, a == b};
			core_pkg::alu_ne:   result = {31'b0, a != b};
			core_pkg::alu_ge:   result = {31'b0, !lt_s};
			default:            result = {31'b0, !lt_u};
		endcase
	end

endmodule

/* rtl/mem_bus_if.sv */
// memory bus interface: one requester's path to the shared memory port
`timescale 1ns/1ps

interface mem_bus_if #(
	parameter int addr_width = 16
);
	logic                  req;
	logic                  we;
	logic [addr_width-1:0] addr;
	logic [31:0]           wdata;
	logic [3:0]            wstrb;
	logic                  gnt;
	logic [31:0]           rdata;
	logic                  rvalid;

	modport requester (output req, we, addr, wdata, wstrb, input gnt, rdata, rvalid);
	modport arbiter (input req, we, addr, wdata, wstrb, output gnt, rdata, rvalid);

endinterface

/* rtl/core_pkg.sv */
// core package: rv32i widths, major opcodes, alu operations and decoded control
package core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	// compare ops give 0 or 1 in bit 0
	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or,
		alu_xor, alu_sll, alu_srl, alu_sra,
		alu_slt, alu_sltu, alu_eq, alu_ne,
		alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef struct packed {
		alu_op_e                alu_op;
		logic                   use_imm;
		logic                   use_pc;
		logic                   is_branch;
		logic                   is_jal;
		logic                   is_jalr;
		logic                   is_load;
		logic                   is_store;
		logic                   reg_wen;
		logic                   halt;
		mem_pkg::mem_size_e     mem_size;
		mem_pkg::load_kind_e    load_kind;
	} ctrl_t;

endpackage

/* rtl/mem_pkg.sv */
// memory package: access sizes, load extension kinds and memory word views
package mem_pkg;

	// encoding follows funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		size_byte = 2'b00,
		size_half = 2'b01,
		size_word = 2'b10
	} mem_size_e;

	// funct3[2] of loads
	typedef enum logic {
		ext_signed   = 1'b0,
		ext_unsigned = 1'b1
	} load_kind_e;

	// one memory word, lane 0 in the low bits
	typedef union packed {
		logic [31:0]      word;
		logic [1:0][15:0] halves;
		logic [3:0][7:0]  bytes;
	} mem_word_u;

endpackage
